// ==== common/id_defines.svh ====
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// datapath and instruction widths
`define ID_XLEN        32
`define ID_INST_W      32

// register file geometry
`define ID_REG_ADDR_W  5
`define ID_NUM_REGS    32

// bl writes the return address here
`define ID_LINK_REG    1

// pc + 4 for the link value
`define ID_PC_STEP     4

`endif

// ==== common/isa_pkg.sv ====
package isa_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui,
        alu_none
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_ld_b, mem_ld_h, mem_ld_w, mem_ld_bu, mem_ld_hu,
        mem_st_b, mem_st_h, mem_st_w
    } mem_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu,
        br_b, br_bl, br_jirl
    } branch_e;

    // inst[31:26], only the groups that are decoded
    typedef enum logic [5:0] {
        op_arith     = 6'h00,
        op_lu12i     = 6'h05,
        op_pcaddu12i = 6'h07,
        op_mem       = 6'h0a,
        op_jirl      = 6'h13,
        op_b         = 6'h14,
        op_bl        = 6'h15,
        op_beq       = 6'h16,
        op_bne       = 6'h17,
        op_blt       = 6'h18,
        op_bge       = 6'h19,
        op_bltu      = 6'h1a,
        op_bgeu      = 6'h1b
    } major_op_e;

endpackage

// ==== common/pipe_pkg.sv ====
`include "id_defines.svh"

package pipe_pkg;

    typedef struct packed {
        logic [`ID_INST_W-1:0] inst;
        logic [`ID_XLEN-1:0]   pc;
    } fetch_pkt_t;

    // decoded bundle handed to execute
    typedef struct packed {
        isa_pkg::alu_op_e            alu_op;
        isa_pkg::mem_op_e            mem_op;
        isa_pkg::branch_e            branch;
        logic                        src1_is_pc;
        logic                        src2_is_imm;
        logic                        gr_we;
        logic [`ID_REG_ADDR_W-1:0]   dest;
        logic [`ID_XLEN-1:0]         imm;
        logic [`ID_XLEN-1:0]         br_offs;
    } ds_ctrl_t;

endpackage

// ==== common/bypass_if.sv ====
`timescale 1ns/10ps
`include "id_defines.svh"

interface bypass_if;
    // execute stage result, es_blk marks a load still in flight
    logic                      es_fwd_valid;
    logic                      es_blk;
    logic [`ID_REG_ADDR_W-1:0] es_dest;
    logic [`ID_XLEN-1:0]       es_data;

    logic                      ms_fwd_valid;
    logic [`ID_REG_ADDR_W-1:0] ms_dest;
    logic [`ID_XLEN-1:0]       ms_data;

    // write-back port, also the register file write
    logic                      wb_we;
    logic [`ID_REG_ADDR_W-1:0] wb_addr;
    logic [`ID_XLEN-1:0]       wb_data;

    modport sink (
        input es_fwd_valid, es_blk, es_dest, es_data,
        input ms_fwd_valid, ms_dest, ms_data,
        input wb_we, wb_addr, wb_data
    );
endinterface

// ==== design/regfile.sv ====
`timescale 1ns/10ps
`include "id_defines.svh"

module regfile (
    input  logic                      clk,
    input  logic [`ID_REG_ADDR_W-1:0] raddr1,
    input  logic [`ID_REG_ADDR_W-1:0] raddr2,
    output logic [`ID_XLEN-1:0]       rdata1,
    output logic [`ID_XLEN-1:0]       rdata2,
    bypass_if.sink                    wr
);

    logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (wr.wb_we && wr.wb_addr != '0) begin
            regs[wr.wb_addr] <= wr.wb_data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== design/id_stage/ds_pipe_reg.sv ====
`timescale 1ns/10ps

module ds_pipe_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fs_valid,
    input  pipe_pkg::fetch_pkt_t fs_pkt,
    input  logic                 es_allowin,
    input  logic [1:0]           hazard,
    input  logic                 br_taken,
    output logic                 ds_allowin,
    output logic                 ds_valid,
    output logic                 issue_valid,
    output pipe_pkg::fetch_pkt_t ds_pkt
);

    logic ready;

    // no load-use stall on either source
    assign ready       = ~|hazard;
    assign issue_valid = ds_valid && ready;
    assign ds_allowin  = !ds_valid || (ready && es_allowin);

    // a taken branch only fires on issue, so ds_allowin is high here
    // and the word fetch presents is the wrong path
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_pkt <= fs_pkt;
        end
    end

endmodule

// ==== design/id_stage/inst_decoder.sv ====
`timescale 1ns/10ps
`include "id_defines.svh"

module inst_decoder (
    input  logic                      ds_valid,
    input  pipe_pkg::fetch_pkt_t      ds_pkt,
    output pipe_pkg::ds_ctrl_t        ctrl,
    output logic [`ID_REG_ADDR_W-1:0] raddr1,
    output logic [`ID_REG_ADDR_W-1:0] raddr2
);

    import isa_pkg::*;

    logic [`ID_INST_W-1:0]     inst;
    major_op_e                 major;
    logic [3:0]                op_25_22;
    logic [1:0]                op_21_20;
    logic [4:0]                op_19_15;
    logic [`ID_REG_ADDR_W-1:0] rd;
    logic [`ID_REG_ADDR_W-1:0] rj;
    logic [`ID_REG_ADDR_W-1:0] rk;
    logic [`ID_XLEN-1:0]       imm_ui5;
    logic [`ID_XLEN-1:0]       imm_si12;
    logic [`ID_XLEN-1:0]       imm_ui12;
    logic [`ID_XLEN-1:0]       imm_u20;
    logic [`ID_XLEN-1:0]       offs16;
    logic [`ID_XLEN-1:0]       offs26;
    logic                      is_store;
    logic                      is_cond_br;

    assign inst     = ds_pkt.inst;
    assign major    = major_op_e'(inst[31:26]);
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];

    assign imm_ui5  = {27'b0, inst[14:10]};
    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui12 = {20'b0, inst[21:10]};
    assign imm_u20  = {inst[24:5], 12'b0};
    assign offs16   = {{14{inst[25]}}, inst[25:10], 2'b0};
    // si26 is split, high part sits in inst[9:0]
    assign offs26   = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    always_comb begin
        ctrl.alu_op      = alu_none;
        ctrl.mem_op      = mem_none;
        ctrl.branch      = br_none;
        ctrl.src1_is_pc  = 1'b0;
        ctrl.src2_is_imm = 1'b0;
        ctrl.imm         = '0;
        case (major)
            op_arith: begin
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    case (op_19_15)
                        5'h00: ctrl.alu_op = alu_add;
                        5'h02: ctrl.alu_op = alu_sub;
                        5'h04: ctrl.alu_op = alu_slt;
                        5'h05: ctrl.alu_op = alu_sltu;
                        5'h08: ctrl.alu_op = alu_nor;
                        5'h09: ctrl.alu_op = alu_and;
                        5'h0a: ctrl.alu_op = alu_or;
                        5'h0b: ctrl.alu_op = alu_xor;
                        5'h0e: ctrl.alu_op = alu_sll;
                        5'h0f: ctrl.alu_op = alu_srl;
                        5'h10: ctrl.alu_op = alu_sra;
                        default: ;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = imm_ui5;
                    case (op_19_15)
                        5'h01: ctrl.alu_op = alu_sll;
                        5'h09: ctrl.alu_op = alu_srl;
                        5'h11: ctrl.alu_op = alu_sra;
                        default: ;
                    endcase
                end else begin
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = imm_si12;
                    case (op_25_22)
                        4'h8: ctrl.alu_op = alu_slt;
                        4'h9: ctrl.alu_op = alu_sltu;
                        4'ha: ctrl.alu_op = alu_add;
                        4'hd: ctrl.alu_op = alu_and;
                        4'he: ctrl.alu_op = alu_or;
                        4'hf: ctrl.alu_op = alu_xor;
                        default: ;
                    endcase
                    // logic immediates are zero extended
                    if (op_25_22 >= 4'hd) begin
                        ctrl.imm = imm_ui12;
                    end
                end
            end
            op_lu12i, op_pcaddu12i: begin
                if (!inst[25]) begin
                    ctrl.alu_op      = (major == op_lu12i) ? alu_lui : alu_add;
                    ctrl.src1_is_pc  = (major == op_pcaddu12i);
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = imm_u20;
                end
            end
            op_mem: begin
                case (op_25_22)
                    4'h0: ctrl.mem_op = mem_ld_b;
                    4'h1: ctrl.mem_op = mem_ld_h;
                    4'h2: ctrl.mem_op = mem_ld_w;
                    4'h4: ctrl.mem_op = mem_st_b;
                    4'h5: ctrl.mem_op = mem_st_h;
                    4'h6: ctrl.mem_op = mem_st_w;
                    4'h8: ctrl.mem_op = mem_ld_bu;
                    4'h9: ctrl.mem_op = mem_ld_hu;
                    default: ;
                endcase
                // address is rj + si12
                if (ctrl.mem_op != mem_none) begin
                    ctrl.alu_op      = alu_add;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = imm_si12;
                end
            end
            op_jirl, op_bl: begin
                ctrl.branch      = (major == op_jirl) ? br_jirl : br_bl;
                ctrl.alu_op      = alu_add;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = `ID_PC_STEP;
            end
            op_b:    ctrl.branch = br_b;
            op_beq:  ctrl.branch = br_beq;
            op_bne:  ctrl.branch = br_bne;
            op_blt:  ctrl.branch = br_blt;
            op_bge:  ctrl.branch = br_bge;
            op_bltu: ctrl.branch = br_bltu;
            op_bgeu: ctrl.branch = br_bgeu;
            default: ;
        endcase

        is_store   = ctrl.mem_op inside {mem_st_b, mem_st_h, mem_st_w};
        is_cond_br = ctrl.branch inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

        // b and conditional branches carry alu_none, so no write
        ctrl.gr_we   = (ctrl.alu_op != alu_none) && !is_store;
        ctrl.dest    = (ctrl.branch == br_bl) ? `ID_REG_ADDR_W'(`ID_LINK_REG) : rd;
        ctrl.br_offs = (ctrl.branch inside {br_b, br_bl}) ? offs26 : offs16;
    end

    // empty stage reads r0, so it never raises a hazard
    assign raddr1 = ds_valid ? rj : '0;
    assign raddr2 = !ds_valid ? '0 : (is_store || is_cond_br) ? rd : rk;

endmodule

// ==== design/id_stage/operand_bypass.sv ====
`timescale 1ns/10ps
`include "id_defines.svh"

module operand_bypass (
    input  logic [`ID_REG_ADDR_W-1:0] raddr,
    input  logic [`ID_XLEN-1:0]       rf_data,
    bypass_if.sink                    byp,
    output logic [`ID_XLEN-1:0]       value,
    output logic                      hazard
);

    logic raddr_nz;
    logic es_hit;
    logic ms_hit;
    logic wb_hit;

    // a write to r0 never forwards
    assign raddr_nz = (raddr != '0);
    assign es_hit   = raddr_nz && byp.es_fwd_valid && (byp.es_dest == raddr);
    assign ms_hit   = raddr_nz && byp.ms_fwd_valid && (byp.ms_dest == raddr);
    assign wb_hit   = raddr_nz && byp.wb_we && (byp.wb_addr == raddr);

    // youngest producer wins
    always_comb begin
        if (es_hit) begin
            value = byp.es_data;
        end else if (ms_hit) begin
            value = byp.ms_data;
        end else if (wb_hit) begin
            value = byp.wb_data;
        end else begin
            value = rf_data;
        end
    end

    // load in execute, data not there yet
    assign hazard = raddr_nz && byp.es_blk && (byp.es_dest == raddr);

endmodule

// ==== design/id_stage/branch_resolve.sv ====
`timescale 1ns/10ps
`include "id_defines.svh"

module branch_resolve (
    input  pipe_pkg::ds_ctrl_t  ctrl,
    input  logic [`ID_XLEN-1:0] ds_pc,
    input  logic                issue_fire,
    input  logic [`ID_XLEN-1:0] rj_value,
    input  logic [`ID_XLEN-1:0] rkd_value,
    output logic                br_taken,
    output logic [`ID_XLEN-1:0] br_target
);

    import isa_pkg::*;

    logic                rj_eq_rd;
    logic                rj_lt_rd;
    logic                rj_ltu_rd;
    logic                cond_met;
    logic [`ID_XLEN-1:0] target_base;

    assign rj_eq_rd  = (rj_value == rkd_value);
    assign rj_lt_rd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rd = (rj_value < rkd_value);

    always_comb begin
        case (ctrl.branch)
            br_beq:  cond_met = rj_eq_rd;
            br_bne:  cond_met = !rj_eq_rd;
            br_blt:  cond_met = rj_lt_rd;
            br_bge:  cond_met = !rj_lt_rd;
            br_bltu: cond_met = rj_ltu_rd;
            br_bgeu: cond_met = !rj_ltu_rd;
            br_b, br_bl, br_jirl: cond_met = 1'b1;
            default: cond_met = 1'b0;
        endcase
    end

    // redirect only when the branch leaves the stage
    assign br_taken = cond_met && issue_fire;

    // jirl is register relative, everything else pc relative
    assign target_base = (ctrl.branch == br_jirl) ? rj_value : ds_pc;
    assign br_target   = target_base + ctrl.br_offs;

endmodule

// ==== design/id_stage/id_stage.sv ====
`timescale 1ns/10ps
`include "id_defines.svh"

module id_stage (
    input  logic                      clk,
    input  logic                      reset,
    // fetch side
    input  logic                      fs_valid,
    input  logic [`ID_INST_W-1:0]     fs_inst,
    input  logic [`ID_XLEN-1:0]       fs_pc,
    output logic                      ds_allowin,
    // execute side
    output logic                      issue_valid,
    input  logic                      es_allowin,
    output isa_pkg::alu_op_e          issue_alu_op,
    output isa_pkg::mem_op_e          issue_mem_op,
    output isa_pkg::branch_e          issue_branch,
    output logic                      issue_src1_is_pc,
    output logic                      issue_src2_is_imm,
    output logic                      issue_gr_we,
    output logic [`ID_REG_ADDR_W-1:0] issue_dest,
    output logic [`ID_XLEN-1:0]       issue_imm,
    output logic [`ID_XLEN-1:0]       issue_rj_value,
    output logic [`ID_XLEN-1:0]       issue_rkd_value,
    output logic [`ID_XLEN-1:0]       issue_pc,
    // bypass sources
    input  logic                      es_fwd_valid,
    input  logic                      es_blk,
    input  logic [`ID_REG_ADDR_W-1:0] es_dest,
    input  logic [`ID_XLEN-1:0]       es_data,
    input  logic                      ms_fwd_valid,
    input  logic [`ID_REG_ADDR_W-1:0] ms_dest,
    input  logic [`ID_XLEN-1:0]       ms_data,
    input  logic                      wb_we,
    input  logic [`ID_REG_ADDR_W-1:0] wb_addr,
    input  logic [`ID_XLEN-1:0]       wb_data,
    // redirect
    output logic                      br_taken,
    output logic [`ID_XLEN-1:0]       br_target
);

    import pipe_pkg::*;

    fetch_pkt_t                fs_pkt;
    fetch_pkt_t                ds_pkt;
    ds_ctrl_t                  ctrl;
    logic                      ds_valid;
    logic                      issue_fire;
    logic [1:0]                hazard;
    logic [`ID_REG_ADDR_W-1:0] raddr   [2];
    logic [`ID_XLEN-1:0]       rf_data [2];
    logic [`ID_XLEN-1:0]       value   [2];

    bypass_if byp ();

    assign byp.es_fwd_valid = es_fwd_valid;
    assign byp.es_blk       = es_blk;
    assign byp.es_dest      = es_dest;
    assign byp.es_data      = es_data;
    assign byp.ms_fwd_valid = ms_fwd_valid;
    assign byp.ms_dest      = ms_dest;
    assign byp.ms_data      = ms_data;
    assign byp.wb_we        = wb_we;
    assign byp.wb_addr      = wb_addr;
    assign byp.wb_data      = wb_data;

    assign fs_pkt     = '{inst: fs_inst, pc: fs_pc};
    assign issue_fire = issue_valid && es_allowin;

    ds_pipe_reg u_pipe (
        .clk         (clk),
        .reset       (reset),
        .fs_valid    (fs_valid),
        .fs_pkt      (fs_pkt),
        .es_allowin  (es_allowin),
        .hazard      (hazard),
        .br_taken    (br_taken),
        .ds_allowin  (ds_allowin),
        .ds_valid    (ds_valid),
        .issue_valid (issue_valid),
        .ds_pkt      (ds_pkt)
    );

    inst_decoder u_dec (
        .ds_valid (ds_valid),
        .ds_pkt   (ds_pkt),
        .ctrl     (ctrl),
        .raddr1   (raddr[0]),
        .raddr2   (raddr[1])
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (raddr[0]),
        .raddr2 (raddr[1]),
        .rdata1 (rf_data[0]),
        .rdata2 (rf_data[1]),
        .wr     (byp)
    );

    // src 0 is rj, src 1 is rk or rd
    for (genvar i = 0; i < 2; i++) begin : g_src
        operand_bypass u_opnd (
            .raddr   (raddr[i]),
            .rf_data (rf_data[i]),
            .byp     (byp),
            .value   (value[i]),
            .hazard  (hazard[i])
        );
    end

    branch_resolve u_br (
        .ctrl       (ctrl),
        .ds_pc      (ds_pkt.pc),
        .issue_fire (issue_fire),
        .rj_value   (value[0]),
        .rkd_value  (value[1]),
        .br_taken   (br_taken),
        .br_target  (br_target)
    );

    assign issue_alu_op      = ctrl.alu_op;
    assign issue_mem_op      = ctrl.mem_op;
    assign issue_branch      = ctrl.branch;
    assign issue_src1_is_pc  = ctrl.src1_is_pc;
    assign issue_src2_is_imm = ctrl.src2_is_imm;
    assign issue_gr_we       = ctrl.gr_we;
    assign issue_dest        = ctrl.dest;
    assign issue_imm         = ctrl.imm;
    assign issue_rj_value    = value[0];
    assign issue_rkd_value   = value[1];
    assign issue_pc          = ds_pkt.pc;

endmodule

// ==== testbench/id_ref_model.svh ====
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// expected decode of one instruction word
function automatic pipe_pkg::ds_ctrl_t decode_expected(input logic [31:0] inst);
    pipe_pkg::ds_ctrl_t c;
    logic               store;
    logic               cond;
    c        = '0;
    c.alu_op = alu_none;
    c.mem_op = mem_none;
    c.branch = br_none;
    c.dest   = inst[4:0];
    case (inst[31:26])
        6'h00: begin
            if (inst[25:20] == 6'h01) begin
                case (inst[19:15])
                    5'h00: c.alu_op = alu_add;
                    5'h02: c.alu_op = alu_sub;
                    5'h04: c.alu_op = alu_slt;
                    5'h05: c.alu_op = alu_sltu;
                    5'h08: c.alu_op = alu_nor;
                    5'h09: c.alu_op = alu_and;
                    5'h0a: c.alu_op = alu_or;
                    5'h0b: c.alu_op = alu_xor;
                    5'h0e: c.alu_op = alu_sll;
                    5'h0f: c.alu_op = alu_srl;
                    5'h10: c.alu_op = alu_sra;
                    default: ;
                endcase
            end else if (inst[25:20] == 6'h04) begin
                case (inst[19:15])
                    5'h01: c.alu_op = alu_sll;
                    5'h09: c.alu_op = alu_srl;
                    5'h11: c.alu_op = alu_sra;
                    default: ;
                endcase
                c.src2_is_imm = 1'b1;
                c.imm         = {27'b0, inst[14:10]};
            end else begin
                case (inst[25:22])
                    4'h8: c.alu_op = alu_slt;
                    4'h9: c.alu_op = alu_sltu;
                    4'ha: c.alu_op = alu_add;
                    4'hd: c.alu_op = alu_and;
                    4'he: c.alu_op = alu_or;
                    4'hf: c.alu_op = alu_xor;
                    default: ;
                endcase
                c.src2_is_imm = 1'b1;
                if (inst[25:22] inside {4'hd, 4'he, 4'hf}) begin
                    c.imm = {20'b0, inst[21:10]};
                end else begin
                    c.imm = {{20{inst[21]}}, inst[21:10]};
                end
            end
        end
        6'h05, 6'h07: begin
            if (!inst[25]) begin
                c.alu_op      = (inst[27]) ? alu_add : alu_lui;
                c.src1_is_pc  = inst[27];
                c.src2_is_imm = 1'b1;
                c.imm         = {inst[24:5], 12'b0};
            end
        end
        6'h0a: begin
            case (inst[25:22])
                4'h0: c.mem_op = mem_ld_b;
                4'h1: c.mem_op = mem_ld_h;
                4'h2: c.mem_op = mem_ld_w;
                4'h4: c.mem_op = mem_st_b;
                4'h5: c.mem_op = mem_st_h;
                4'h6: c.mem_op = mem_st_w;
                4'h8: c.mem_op = mem_ld_bu;
                4'h9: c.mem_op = mem_ld_hu;
                default: ;
            endcase
            if (c.mem_op != mem_none) begin
                c.alu_op      = alu_add;
                c.src2_is_imm = 1'b1;
                c.imm         = {{20{inst[21]}}, inst[21:10]};
            end
        end
        6'h13, 6'h15: begin
            c.branch      = (inst[31:26] == 6'h15) ? br_bl : br_jirl;
            c.alu_op      = alu_add;
            c.src1_is_pc  = 1'b1;
            c.src2_is_imm = 1'b1;
            c.imm         = 32'd4;
            if (c.branch == br_bl) begin
                c.dest = 5'd1;
            end
        end
        6'h14: c.branch = br_b;
        6'h16: c.branch = br_beq;
        6'h17: c.branch = br_bne;
        6'h18: c.branch = br_blt;
        6'h19: c.branch = br_bge;
        6'h1a: c.branch = br_bltu;
        6'h1b: c.branch = br_bgeu;
        default: ;
    endcase
    store   = c.mem_op inside {mem_st_b, mem_st_h, mem_st_w};
    cond    = c.branch inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
    c.gr_we = !(store || cond || c.branch == br_b || c.alu_op == alu_none);
    if (c.branch inside {br_b, br_bl}) begin
        c.br_offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
    end else begin
        c.br_offs = {{14{inst[25]}}, inst[25:10], 2'b0};
    end
    return c;
endfunction

// second source is rd for stores and conditional branches
function automatic logic [4:0] src2_addr(input logic [31:0] inst);
    pipe_pkg::ds_ctrl_t c;
    c = decode_expected(inst);
    if (c.mem_op inside {mem_st_b, mem_st_h, mem_st_w} ||
        c.branch inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu}) begin
        return inst[4:0];
    end
    return inst[14:10];
endfunction

function automatic logic load_blocked(input logic [4:0] addr);
    return addr != 5'd0 && es_blk && es_dest == addr;
endfunction

// youngest producer first, then the shadow registers
function automatic logic [31:0] forwarded_value(input logic [4:0] addr);
    if (addr == 5'd0) begin
        return 32'd0;
    end else if (es_fwd_valid && es_dest == addr) begin
        return es_data;
    end else if (ms_fwd_valid && ms_dest == addr) begin
        return ms_data;
    end else if (wb_we && wb_addr == addr) begin
        return wb_data;
    end
    return shadow[addr];
endfunction

task automatic branch_outcome(input pipe_pkg::ds_ctrl_t c, input logic [31:0] pc,
                              input logic [31:0] a, input logic [31:0] b,
                              output logic taken, output logic [31:0] target);
    case (c.branch)
        br_beq:  taken = (a == b);
        br_bne:  taken = (a != b);
        br_blt:  taken = ($signed(a) < $signed(b));
        br_bge:  taken = ($signed(a) >= $signed(b));
        br_bltu: taken = (a < b);
        br_bgeu: taken = (a >= b);
        br_b, br_bl, br_jirl: taken = 1'b1;
        default: taken = 1'b0;
    endcase
    target = ((c.branch == br_jirl) ? a : pc) + c.br_offs;
endtask

`endif

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/10ps

module tb_id_stage;

    import isa_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    logic        fs_valid;
    logic [31:0] fs_inst;
    logic [31:0] fs_pc;
    logic        ds_allowin;
    logic        issue_valid;
    logic        es_allowin;
    alu_op_e     issue_alu_op;
    mem_op_e     issue_mem_op;
    branch_e     issue_branch;
    logic        issue_src1_is_pc;
    logic        issue_src2_is_imm;
    logic        issue_gr_we;
    logic [4:0]  issue_dest;
    logic [31:0] issue_imm;
    logic [31:0] issue_rj_value;
    logic [31:0] issue_rkd_value;
    logic [31:0] issue_pc;
    logic        es_fwd_valid;
    logic        es_blk;
    logic [4:0]  es_dest;
    logic [31:0] es_data;
    logic        ms_fwd_valid;
    logic [4:0]  ms_dest;
    logic [31:0] ms_data;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        br_taken;
    logic [31:0] br_target;

    logic [31:0]          lcg_state = 32'hda504780;
    logic [31:0]          shadow [32];
    pipe_pkg::fetch_pkt_t held_q [$];
    int                   stall_cycles = 0;
    int                   issued = 0;
    int                   wait_cycles;

    logic [4:0] reg_codes   [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                     5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    logic [4:0] shift_codes [3]  = '{5'h01, 5'h09, 5'h11};
    logic [3:0] imm_codes   [6]  = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    logic [3:0] mem_codes   [8]  = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9};
    logic [5:0] cond_ops    [6]  = '{6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b};

    `include "id_ref_model.svh"

    id_stage i_dut (.*);

    always #10 clk = !clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // registers kept in r0..r7 so that bypass matches are frequent
    function automatic logic [31:0] make_instruction();
        logic [31:0] r;
        logic [31:0] f;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        r  = next_rand();
        f  = next_rand();
        rd = {2'b0, f[2:0]};
        rj = {2'b0, f[5:3]};
        rk = {2'b0, f[8:6]};
        case (r[31:28])
            4'd0, 4'd1: return {12'h001, reg_codes[4'(r % 11)], rk, rj, rd};
            4'd2: return {12'h004, shift_codes[2'(r % 3)], f[14:10], rj, rd};
            4'd3, 4'd4: return {6'h00, imm_codes[3'(r % 6)], f[30:19], rj, rd};
            4'd5: return {(r[0] ? 6'h07 : 6'h05), 1'b0, f[28:9], rd};
            4'd6, 4'd7: return {6'h0a, mem_codes[r[2:0]], f[30:19], rj, rd};
            4'd8: return {6'h13, f[31:16], rj, rd};
            4'd9: return {(r[0] ? 6'h15 : 6'h14), f[25:0]};
            4'd10, 4'd11, 4'd12, 4'd13: return {cond_ops[3'(r % 6)], f[31:16], rj, rd};
            default: return f;
        endcase
    endfunction

    task automatic fail_with(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // mode 0 random, 1 register preload, 2 drain
    task automatic drive_inputs(input logic [1:0] mode, input logic [4:0] pre_addr);
        logic [31:0] r;
        logic [31:0] pc;
        r  = next_rand();
        pc = next_rand();
        fs_valid     <= (mode == 2'd0) && (r[1:0] != 2'b0);
        fs_inst      <= make_instruction();
        fs_pc        <= {pc[31:2], 2'b0};
        es_allowin   <= (mode == 2'd2) || (r[3:2] != 2'b0);
        es_blk       <= (mode != 2'd2) && (r[5:4] == 2'b0);
        es_fwd_valid <= r[6];
        es_dest      <= {2'b0, r[9:7]};
        es_data      <= next_rand();
        ms_fwd_valid <= r[10];
        ms_dest      <= {2'b0, r[13:11]};
        ms_data      <= next_rand();
        wb_we        <= (mode == 2'd1) || r[14];
        wb_addr      <= (mode == 2'd1) ? pre_addr : {2'b0, r[17:15]};
        wb_data      <= next_rand();
    endtask

    task automatic sample_and_check();
        pipe_pkg::ds_ctrl_t   exp;
        pipe_pkg::fetch_pkt_t head;
        logic [4:0]           a1;
        logic [4:0]           a2;
        logic                 busy;
        logic                 haz;
        logic                 allow;
        logic                 taken;
        logic [31:0]          target;
        busy  = held_q.size() > 0;
        haz   = 1'b0;
        taken = 1'b0;
        if (busy) begin
            head = held_q[0];
            exp  = decode_expected(head.inst);
            a1   = head.inst[9:5];
            a2   = src2_addr(head.inst);
            haz  = load_blocked(a1) || load_blocked(a2);
        end
        allow = !busy || (!haz && es_allowin);
        check_eq("issue_valid", 32'(issue_valid), 32'(busy && !haz));
        check_eq("ds_allowin", 32'(ds_allowin), 32'(allow));
        if (busy && !haz && es_allowin) begin
            check_eq("issue_pc", issue_pc, head.pc);
            check_eq("issue_alu_op", 32'(issue_alu_op), 32'(exp.alu_op));
            check_eq("issue_mem_op", 32'(issue_mem_op), 32'(exp.mem_op));
            check_eq("issue_branch", 32'(issue_branch), 32'(exp.branch));
            check_eq("issue_gr_we", 32'(issue_gr_we), 32'(exp.gr_we));
            // invalid words only promise no write and no memory access
            if (exp.alu_op != alu_none || exp.branch != br_none) begin
                check_eq("issue_dest", 32'(issue_dest), 32'(exp.dest));
                check_eq("issue_src1_is_pc", 32'(issue_src1_is_pc), 32'(exp.src1_is_pc));
                check_eq("issue_src2_is_imm", 32'(issue_src2_is_imm), 32'(exp.src2_is_imm));
                check_eq("issue_imm", issue_imm, exp.imm);
            end
            check_eq("issue_rj_value", issue_rj_value, forwarded_value(a1));
            check_eq("issue_rkd_value", issue_rkd_value, forwarded_value(a2));
            branch_outcome(exp, head.pc, forwarded_value(a1), forwarded_value(a2),
                           taken, target);
            if (taken) begin
                check_eq("br_target", br_target, target);
            end
            void'(held_q.pop_front());
            issued++;
            stall_cycles = 0;
        end else if (busy) begin
            stall_cycles++;
            if (stall_cycles > 64) begin
                fail_with("held instruction did not issue within 64 cycles");
            end
        end
        check_eq("br_taken", 32'(br_taken), 32'(taken));
        // the wrong-path word behind a taken branch is dropped
        if (fs_valid && allow && !taken) begin
            held_q.push_back('{inst: fs_inst, pc: fs_pc});
        end
        if (wb_we && wb_addr != 5'd0) begin
            shadow[wb_addr] = wb_data;
        end
    endtask

    initial begin
        reset        = 1'b1;
        fs_valid     = 1'b0;
        fs_inst      = '0;
        fs_pc        = '0;
        es_allowin   = 1'b0;
        es_fwd_valid = 1'b0;
        es_blk       = 1'b0;
        es_dest      = '0;
        es_data      = '0;
        ms_fwd_valid = 1'b0;
        ms_dest      = '0;
        ms_data      = '0;
        wb_we        = 1'b0;
        wb_addr      = '0;
        wb_data      = '0;
        shadow[0]    = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_eq("issue_valid", 32'(issue_valid), 32'd0);
        check_eq("br_taken", 32'(br_taken), 32'd0);
        check_eq("ds_allowin", 32'(ds_allowin), 32'd1);

        for (int a = 1; a < 32; a++) begin
            @(posedge clk);
            drive_inputs(2'd1, 5'(a));
            @(negedge clk);
            sample_and_check();
        end
        repeat (4000) begin
            @(posedge clk);
            drive_inputs(2'd0, 5'd0);
            @(negedge clk);
            sample_and_check();
        end

        wait_cycles = 0;
        while (held_q.size() > 0) begin
            wait_cycles++;
            if (wait_cycles > 50) begin
                fail_with("pipeline did not drain within 50 cycles");
            end
            @(posedge clk);
            drive_inputs(2'd2, 5'd0);
            @(negedge clk);
            sample_and_check();
        end

        if (issued >= 1000) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("only %0d instructions issued", issued);
            $display("Testbench failed");
            $fatal(1);
        end
    end

endmodule

// ==== project.f ====
+incdir+common
+incdir+testbench
common/isa_pkg.sv
common/pipe_pkg.sv
common/bypass_if.sv
design/regfile.sv
design/id_stage/ds_pipe_reg.sv
design/id_stage/inst_decoder.sv
design/id_stage/operand_bypass.sv
design/id_stage/branch_resolve.sv
design/id_stage/id_stage.sv
testbench/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module tb_id_stage -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Testbench passed" && exit 0 || exit 1
